// ==== design/frontend_pkg.sv ====
package frontend_pkg;

    parameter int xlen = 32;

    // counter table is indexed by pc[bht_index_bits+1:2]
    parameter int bht_index_bits = 4;

    // instruction buffer entries, power of two and at least 4
    parameter int buf_depth = 8;

    localparam logic [5:0] op_jmp = 6'h02;
    localparam logic [5:0] op_br  = 6'h04;

    // jump and branch layout, offset counts words
    typedef struct packed {
        logic [5:0]         opcode;
        logic [9:0]         unused;
        logic signed [15:0] offset;
    } branch_fields_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        branch_fields_t  br;
    } inst_word_u;

    // one slot as seen by the decoder
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            pred_taken;
        logic [xlen-1:0] pred_target;
    } buf_entry_t;

endpackage

// ==== design/fetch_group_if.sv ====
`timescale 1ns/1ps

// one returned fetch pair with its predictions, no handshake
interface fetch_group_if;

    logic [1:0]                     valid;
    frontend_pkg::buf_entry_t [1:0] entry;

    modport predictor (
        output valid,
        output entry
    );

    modport buffer (
        input valid,
        input entry
    );

endinterface

// ==== design/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic [frontend_pkg::xlen-1:0] new_pc,
    input  logic                          resp_valid,
    input  logic                          bpu_flush,
    input  logic [frontend_pkg::xlen-1:0] pred_target,
    input  logic                          buffer_full,
    output logic                          fetch_req,
    output logic [frontend_pkg::xlen-1:0] fetch_pc,
    output logic [1:0]                    slot_en,
    output logic                          resp_live
);

    // full fetch address, bit 2 may be set after a redirect
    logic [frontend_pkg::xlen-1:0] pc_q;
    logic                          waiting;
    logic                          busy;
    logic                          stale;

    assign fetch_req = waiting && !busy && !buffer_full;
    assign fetch_pc  = {pc_q[frontend_pkg::xlen-1:3], 3'b000};
    assign slot_en   = {1'b1, ~pc_q[2]};

    // a response arriving with a flush is dropped as well
    assign resp_live = busy && !stale && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= '0;
            waiting <= 1'b0;
            busy    <= 1'b0;
            stale   <= 1'b0;
        end else if (flush) begin
            pc_q    <= new_pc;
            waiting <= 1'b1;
            // anything in flight comes back stale, and the new request
            // waits for it so only one stays outstanding
            busy    <= (busy && !resp_valid) || fetch_req;
            stale   <= (busy && !resp_valid) || fetch_req;
        end else if (fetch_req) begin
            waiting <= 1'b0;
            busy    <= 1'b1;
        end else if (busy && resp_valid) begin
            busy    <= 1'b0;
            stale   <= 1'b0;
            waiting <= 1'b1;
            if (!stale) begin
                pc_q <= bpu_flush ? pred_target : fetch_pc + 32'd8;
            end
        end else if (!waiting && !busy) begin
            // first request after reset
            waiting <= 1'b1;
        end
    end

endmodule

// ==== design/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BHT_INDEX_BITS = frontend_pkg::bht_index_bits
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          resp_valid,
    input  logic                          resp_live,
    input  logic [1:0]                    slot_en,
    input  logic [frontend_pkg::xlen-1:0] resp_pc,
    input  logic [frontend_pkg::xlen-1:0] resp_inst0,
    input  logic [frontend_pkg::xlen-1:0] resp_inst1,
    input  logic                          update_valid,
    input  logic [frontend_pkg::xlen-1:0] update_pc,
    input  logic                          update_taken,
    output logic                          bpu_flush,
    output logic [frontend_pkg::xlen-1:0] pred_target,
    fetch_group_if.predictor              group
);

    localparam int bht_size = 1 << BHT_INDEX_BITS;

    // 2-bit saturating counters, msb set means taken
    logic [1:0]                    bht [bht_size];
    frontend_pkg::inst_word_u      inst_w [2];
    logic [frontend_pkg::xlen-1:0] slot_pc [2];
    logic [frontend_pkg::xlen-1:0] offset_bytes [2];
    logic [frontend_pkg::xlen-1:0] jump_target [2];
    logic [1:0]                    taken;
    logic [BHT_INDEX_BITS-1:0]     upd_idx;
    logic                          live;

    always_comb begin
        inst_w[0].raw = resp_inst0;
        inst_w[1].raw = resp_inst1;
        slot_pc[0]    = {resp_pc[frontend_pkg::xlen-1:3], 3'b000};
        slot_pc[1]    = {resp_pc[frontend_pkg::xlen-1:3], 3'b100};
        for (int i = 0; i < 2; i++) begin
            offset_bytes[i] = {{14{inst_w[i].br.offset[15]}}, inst_w[i].br.offset, 2'b00};
            jump_target[i]  = slot_pc[i] + offset_bytes[i];
            case (inst_w[i].br.opcode)
                frontend_pkg::op_jmp: begin
                    taken[i] = slot_en[i];
                end
                frontend_pkg::op_br: begin
                    taken[i] = slot_en[i] && bht[slot_pc[i][BHT_INDEX_BITS+1:2]][1];
                end
                default: begin
                    taken[i] = 1'b0;
                end
            endcase
        end
    end

    assign live        = resp_valid && resp_live;
    assign bpu_flush   = live && (taken[0] || taken[1]);
    assign pred_target = taken[0] ? jump_target[0] : jump_target[1];

    // a taken slot 0 kills the younger slot
    always_comb begin
        group.valid[0] = live && slot_en[0];
        group.valid[1] = live && slot_en[1] && !taken[0];
        for (int i = 0; i < 2; i++) begin
            group.entry[i].pc          = slot_pc[i];
            group.entry[i].inst        = inst_w[i].raw;
            group.entry[i].pred_taken  = taken[i];
            group.entry[i].pred_target = taken[i] ? jump_target[i] : slot_pc[i] + 32'd4;
        end
    end

    assign upd_idx = update_pc[BHT_INDEX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // weakly not taken
            for (int i = 0; i < bht_size; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (update_valid) begin
            if (update_taken && bht[upd_idx] != 2'b11) begin
                bht[upd_idx] <= bht[upd_idx] + 2'b01;
            end else if (!update_taken && bht[upd_idx] != 2'b00) begin
                bht[upd_idx] <= bht[upd_idx] - 2'b01;
            end
        end
    end

endmodule

// ==== design/inst_buffer.sv ====
`timescale 1ns/1ps

module inst_buffer #(
    parameter int BUF_DEPTH = frontend_pkg::buf_depth
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     pause_decoder,
    fetch_group_if.buffer            group,
    output logic [1:0]               out_valid,
    output frontend_pkg::buf_entry_t out_entry0,
    output frontend_pkg::buf_entry_t out_entry1,
    output logic                     buffer_full
);

    // pointers wrap on their own width
    localparam int ptr_bits = $clog2(BUF_DEPTH);
    localparam logic [ptr_bits:0] cnt_one    = (ptr_bits+1)'(1);
    localparam logic [ptr_bits:0] cnt_two    = (ptr_bits+1)'(2);
    localparam logic [ptr_bits:0] full_level = (ptr_bits+1)'(BUF_DEPTH - 2);

    frontend_pkg::buf_entry_t mem [BUF_DEPTH];
    logic [ptr_bits-1:0]      rd_ptr;
    logic [ptr_bits-1:0]      rd_next;
    logic [ptr_bits-1:0]      wr_ptr;
    logic [ptr_bits-1:0]      wr_next;
    logic [ptr_bits:0]        count;
    logic [ptr_bits:0]        n_wr;
    logic [ptr_bits:0]        n_rd;

    assign rd_next = rd_ptr + 1'b1;
    assign wr_next = wr_ptr + 1'b1;

    // oldest two entries go to the decoder
    assign out_valid[0] = count != '0;
    assign out_valid[1] = count >= cnt_two;
    assign out_entry0   = mem[rd_ptr];
    assign out_entry1   = mem[rd_next];

    // fewer than two free slots left
    assign buffer_full = count > full_level;

    always_comb begin
        case (group.valid)
            2'b00:   n_wr = '0;
            2'b11:   n_wr = cnt_two;
            default: n_wr = cnt_one;
        endcase
        if (pause_decoder) begin
            n_rd = '0;
        end else if (out_valid[1]) begin
            n_rd = cnt_two;
        end else if (out_valid[0]) begin
            n_rd = cnt_one;
        end else begin
            n_rd = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + n_rd[ptr_bits-1:0];
            wr_ptr <= wr_ptr + n_wr[ptr_bits-1:0];
            count  <= count + n_wr - n_rd;
        end
    end

    // slot 1 lands right after slot 0, or alone when slot 0 was skipped
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (group.valid[0]) begin
                mem[wr_ptr] <= group.entry[0];
            end
            if (group.valid[1]) begin
                mem[group.valid[0] ? wr_next : wr_ptr] <= group.entry[1];
            end
        end
    end

endmodule

// ==== design/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top #(
    parameter int BHT_INDEX_BITS = frontend_pkg::bht_index_bits,
    parameter int BUF_DEPTH      = frontend_pkg::buf_depth
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // instruction cache
    output logic                          fetch_req,
    output logic [frontend_pkg::xlen-1:0] fetch_pc,
    input  logic                          resp_valid,
    input  logic [frontend_pkg::xlen-1:0] resp_pc,
    input  logic [frontend_pkg::xlen-1:0] resp_inst0,
    input  logic [frontend_pkg::xlen-1:0] resp_inst1,

    // backend
    input  logic                          flush,
    input  logic [frontend_pkg::xlen-1:0] new_pc,
    input  logic                          update_valid,
    input  logic [frontend_pkg::xlen-1:0] update_pc,
    input  logic                          update_taken,
    input  logic                          pause_decoder,
    output logic [1:0]                    out_valid,
    output frontend_pkg::buf_entry_t      out_entry0,
    output frontend_pkg::buf_entry_t      out_entry1,
    output logic                          buffer_full,
    output logic                          bpu_flush
);

    logic [1:0]                    slot_en;
    logic                          resp_live;
    logic [frontend_pkg::xlen-1:0] pred_target;

    fetch_group_if group_if ();

    fetch_pc_gen u_pc_gen (
        .clk,
        .rst_n,
        .flush,
        .new_pc,
        .resp_valid,
        .bpu_flush,
        .pred_target,
        .buffer_full,
        .fetch_req,
        .fetch_pc,
        .slot_en,
        .resp_live
    );

    branch_predictor #(
        .BHT_INDEX_BITS(BHT_INDEX_BITS)
    ) u_bpu (
        .clk,
        .rst_n,
        .resp_valid,
        .resp_live,
        .slot_en,
        .resp_pc,
        .resp_inst0,
        .resp_inst1,
        .update_valid,
        .update_pc,
        .update_taken,
        .bpu_flush,
        .pred_target,
        .group(group_if.predictor)
    );

    inst_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_buffer (
        .clk,
        .rst_n,
        .flush,
        .pause_decoder,
        .group(group_if.buffer),
        .out_valid,
        .out_entry0,
        .out_entry1,
        .buffer_full
    );

endmodule

// ==== verif/frontend_asserts.sv ====
`timescale 1ns/1ps

module frontend_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     flush,
    input logic                     pause_decoder,
    input logic                     fetch_req,
    input logic                     resp_valid,
    input logic                     bpu_flush,
    input logic                     buffer_full,
    input logic [1:0]               out_valid,
    input frontend_pkg::buf_entry_t out_entry0,
    input logic [1:0]               wr_valid
);

    logic outstanding;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (fetch_req) begin
            outstanding <= 1'b1;
        end else if (resp_valid) begin
            outstanding <= 1'b0;
        end
    end

    single_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |-> !outstanding)
        else $error("fetch_req while a request is outstanding");

    flush_with_resp: assert property (@(posedge clk) disable iff (!rst_n)
        bpu_flush |-> resp_valid && outstanding && !flush)
        else $error("bpu_flush without a live response");

    hold_while_paused: assert property (@(posedge clk) disable iff (!rst_n)
        pause_decoder && !flush && out_valid[0] |=> out_valid[0] && $stable(out_entry0))
        else $error("head entry changed while the decoder was paused");

    no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        buffer_full |-> wr_valid == 2'b00)
        else $error("buffer written while full");

endmodule

bind frontend_top frontend_asserts asserts_i (
    .clk,
    .rst_n,
    .flush,
    .pause_decoder,
    .fetch_req,
    .resp_valid,
    .bpu_flush,
    .buffer_full,
    .out_valid,
    .out_entry0,
    .wr_valid(group_if.valid)
);

// ==== verif/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;

    typedef struct {
        logic [31:0] pc;
        int          n_upd;
        logic        upd_taken;
        int          n_exp;
        logic        rand_pause;
    } phase_t;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     fetch_req;
    logic [31:0]              fetch_pc;
    logic                     resp_valid = 1'b0;
    logic [31:0]              resp_pc = '0;
    logic [31:0]              resp_inst0 = '0;
    logic [31:0]              resp_inst1 = '0;
    logic                     flush;
    logic [31:0]              new_pc;
    logic                     update_valid;
    logic [31:0]              update_pc;
    logic                     update_taken;
    logic                     pause_decoder = 1'b0;
    logic [1:0]               out_valid;
    frontend_pkg::buf_entry_t out_entry0;
    frontend_pkg::buf_entry_t out_entry1;
    logic                     buffer_full;
    logic                     bpu_flush;

    logic [31:0]              prog [32];
    logic [1:0]               bht_model [16];
    phase_t                   phases [6];
    frontend_pkg::buf_entry_t exp_q [$];
    logic [15:0]              lfsr = 16'd34;
    logic                     hold = 1'b0;
    logic                     rand_pause = 1'b0;
    logic                     collecting = 1'b0;
    logic                     saw_full = 1'b0;
    int                       errors = 0;
    int                       got = 0;

    always #2 clk = ~clk;

    frontend_top dut_i (.*);

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // expected entry for one slot under the prediction rules
    function automatic frontend_pkg::buf_entry_t predict(input logic [31:0] pc);
        frontend_pkg::inst_word_u w;
        frontend_pkg::buf_entry_t e;
        w.raw = prog[pc[6:2]];
        e.pc = pc;
        e.inst = w.raw;
        e.pred_taken = (w.br.opcode == frontend_pkg::op_jmp) ||
                       (w.br.opcode == frontend_pkg::op_br && bht_model[pc[5:2]] >= 2'd2);
        e.pred_target = e.pred_taken ?
            pc + {{14{w.br.offset[15]}}, w.br.offset, 2'b00} : pc + 32'd4;
        return e;
    endfunction

    task automatic check_entry(input string name, input frontend_pkg::buf_entry_t act,
                               input frontend_pkg::buf_entry_t exp);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [frontend_pkg::xlen-1:0] act,
                              input logic [frontend_pkg::xlen-1:0] exp);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, act, exp);
        end
    endtask

    // cache model, pause driver and counter model share the lfsr in one process
    always @(posedge clk) begin : cache_model
        int v;
        static bit pending = 0;
        static int lat_left = 0;
        static logic [31:0] pend_pc = '0;
        resp_valid <= 1'b0;
        if (update_valid) begin
            if (update_taken && bht_model[update_pc[5:2]] != 2'd3) begin
                bht_model[update_pc[5:2]] = bht_model[update_pc[5:2]] + 2'd1;
            end else if (!update_taken && bht_model[update_pc[5:2]] != 2'd0) begin
                bht_model[update_pc[5:2]] = bht_model[update_pc[5:2]] - 2'd1;
            end
        end
        if (pending) begin
            lat_left--;
            if (lat_left == 0) begin
                resp_valid <= 1'b1;
                resp_pc    <= pend_pc;
                resp_inst0 <= prog[pend_pc[6:2]];
                resp_inst1 <= prog[pend_pc[6:2] + 5'd1];
                pending = 0;
            end
        end else if (rst_n && fetch_req) begin
            pending = 1;
            pend_pc = fetch_pc;
            lat_left = 1 + rand_bits(2) % 3;
        end
        if (hold) begin
            pause_decoder <= 1'b1;
        end else if (rand_pause) begin
            v = rand_bits(1);
            pause_decoder <= v[0];
        end else begin
            pause_decoder <= 1'b0;
        end
    end

    // fetch state, buffer occupancy and the decoder side at mid-cycle
    always @(negedge clk) begin : frontend_model
        frontend_pkg::buf_entry_t e;
        static bit busy_m = 0;
        static bit stale_m = 0;
        static logic [31:0] req_pc_m = '0;
        static logic [31:0] next_pc_m = '0;
        static int occ = 0;
        int n_wr;
        int n_rd;
        n_wr = 0;
        e = predict(req_pc_m);
        if (rst_n && resp_valid && busy_m && !stale_m && !flush) begin
            n_wr = 1;
            if (!e.pred_taken && !req_pc_m[2]) begin
                e = predict(req_pc_m + 32'd4);
                n_wr = 2;
            end
        end
        check_bit("bpu_flush", bpu_flush, n_wr != 0 && e.pred_taken);
        check_bit("buffer_full", buffer_full, occ > 6);
        check_bit("out_valid[0]", out_valid[0], occ >= 1);
        check_bit("out_valid[1]", out_valid[1], occ >= 2);
        if (rst_n && fetch_req) begin
            check_addr("fetch_pc", fetch_pc, {next_pc_m[31:3], 3'b000});
        end
        if (hold && buffer_full) begin
            saw_full = 1'b1;
            check_bit("fetch_req", fetch_req, 1'b0);
        end
        if (!collecting) begin
            got = 0;
        end else begin
            // while paused the head keeps showing the next expected entry
            if (out_valid[0] && got < exp_q.size()) begin
                check_entry("out_entry0", out_entry0, exp_q[got]);
            end
            if (out_valid[1] && got + 1 < exp_q.size()) begin
                check_entry("out_entry1", out_entry1, exp_q[got + 1]);
            end
            if (!pause_decoder && out_valid[0] && got < exp_q.size()) begin
                got++;
            end
            if (!pause_decoder && out_valid[1] && got < exp_q.size()) begin
                got++;
            end
        end
        n_rd = pause_decoder ? 0 : (occ >= 2 ? 2 : occ);
        if (!rst_n) begin
            busy_m = 0;
            stale_m = 0;
            next_pc_m = '0;
            occ = 0;
        end else if (flush) begin
            next_pc_m = new_pc;
            stale_m = (busy_m && !resp_valid) || fetch_req;
            busy_m = stale_m;
            occ = 0;
        end else begin
            if (fetch_req) begin
                req_pc_m = next_pc_m;
                busy_m = 1;
            end else if (resp_valid && busy_m) begin
                if (!stale_m) begin
                    next_pc_m = e.pred_taken && n_wr != 0 ? e.pred_target
                              : {req_pc_m[31:3], 3'b000} + 32'd8;
                end
                busy_m = 0;
                stale_m = 0;
            end
            occ = occ + n_wr - n_rd;
        end
    end

    initial begin : stimulus
        logic [31:0] pc;
        rst_n = 1'b0;
        flush = 1'b0;
        new_pc = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        for (int i = 0; i < 32; i++) begin
            prog[i] = 32'h0400_0000 | 32'(i);
        end
        prog[8]  = 32'h0800_0009;
        prog[24] = 32'h1000_0004;
        for (int i = 0; i < 16; i++) begin
            bht_model[i] = 2'd1;
        end
        // start pc, updates, update direction, deliveries, random pause
        phases[0] = '{32'h00, 0, 1'b0, 8, 1'b0};
        phases[1] = '{32'h20, 0, 1'b0, 5, 1'b0};
        phases[2] = '{32'h60, 0, 1'b0, 3, 1'b0};
        phases[3] = '{32'h60, 2, 1'b1, 5, 1'b0};
        phases[4] = '{32'h60, 2, 1'b0, 3, 1'b0};
        phases[5] = '{32'h00, 0, 1'b0, 20, 1'b1};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < 6; p++) begin
            for (int u = 0; u < phases[p].n_upd; u++) begin
                @(posedge clk);
                update_valid <= 1'b1;
                update_pc    <= phases[p].pc;
                update_taken <= phases[p].upd_taken;
            end
            @(posedge clk);
            update_valid <= 1'b0;
            @(posedge clk);
            exp_q.delete();
            pc = phases[p].pc;
            while (exp_q.size() < phases[p].n_exp) begin
                exp_q.push_back(predict(pc));
                pc = exp_q[$].pred_target;
            end
            if (p > 0) begin
                flush  <= 1'b1;
                new_pc <= phases[p].pc;
                hold   <= phases[p].rand_pause;
                @(posedge clk);
                flush <= 1'b0;
            end
            collecting <= 1'b1;
            if (phases[p].rand_pause) begin
                repeat (30) @(posedge clk);
                if (!saw_full) begin
                    errors++;
                    $display("buffer_full never rose while the decoder was paused");
                end
                hold <= 1'b0;
                rand_pause <= 1'b1;
            end
            wait (got == phases[p].n_exp);
            @(posedge clk);
            collecting <= 1'b0;
            rand_pause <= 1'b0;
        end
        @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        int total;
        total = 0;
        #1;
        for (int p = 0; p < 6; p++) begin
            total += phases[p].n_exp;
        end
        #(total * 40 * 4);
        $display("timeout: the frontend stopped delivering instructions");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
design/frontend_pkg.sv
design/fetch_group_if.sv
design/fetch_pc_gen.sv
design/branch_predictor.sv
design/inst_buffer.sv
design/frontend_top.sv
verif/frontend_asserts.sv
verif/frontend_tb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module frontend_tb -o sim
	out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing -f build.f --top-module frontend_tb

clean:
	rm -rf obj_dir
